// ==== source/board_pkg.sv ====
`default_nettype none

package board_pkg;

    // Timing values scaled down so a simulation finishes quickly
    localparam logic [3:0] clks_per_bit   = 4'd8;  // Clocks per serial bit
    localparam logic [2:0] sample_cnt_max = 3'd4;  // Clocks between debounce samples
    localparam logic [1:0] pulse_cnt_max  = 2'd3;  // Steady high samples for a press

    // Command opcodes, 00 and 11 are ignored
    localparam logic [1:0] op_read  = 2'b01;
    localparam logic [1:0] op_write = 2'b10;

    // Write view of a command byte
    typedef struct packed {
        logic [1:0] op;
        logic [5:0] led_val;  // New LED value for csr byte 0
    } write_cmd_t;

    // Read view of a command byte
    typedef struct packed {
        logic [1:0] op;
        logic [3:0] rsvd;     // Don't care
        logic [1:0] sel;      // Which csr byte to send back
    } read_cmd_t;

    // One received byte, seen either way
    typedef union packed {
        write_cmd_t wr;
        read_cmd_t  rd;
    } cmd_t;

endpackage

`default_nettype wire

// ==== source/byte_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// Byte traffic between the UART and the command unit
interface byte_if;

    logic [7:0] rx_data;   // Received byte, good while rx_valid is high
    logic       rx_valid;  // One clock per good frame
    logic [7:0] tx_data;   // Byte to send
    logic       tx_start;  // One clock, only while tx_busy is low
    logic       tx_busy;   // Frame in flight

    modport uart_side (
        output rx_data, rx_valid, tx_busy,
        input  tx_data, tx_start
    );

    modport host_side (
        input  rx_data, rx_valid, tx_busy,
        output tx_data, tx_start
    );

endinterface

`default_nettype wire

// ==== source/button_parser.sv ====
`timescale 1ns/1ns
`default_nettype none

module button_parser import board_pkg::*; #(
    parameter int width = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [width-1:0] in,   // Raw button levels
    output logic [width-1:0] out   // One pulse per press
);

    logic [width-1:0] in_meta;     // First synchronizer stage
    logic [width-1:0] in_sync;     // Safe to use from here on
    logic [2:0]       sample_cnt;
    logic             tick;

    // Two flop synchronizer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_meta <= '0;
            in_sync <= '0;
        end else begin
            in_meta <= in;
            in_sync <= in_meta;
        end
    end

    // Sample tick shared by all buttons
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample_cnt <= '0;
        end else if (tick) begin
            sample_cnt <= '0;
        end else begin
            sample_cnt <= sample_cnt + 3'd1;
        end
    end

    assign tick = (sample_cnt == sample_cnt_max - 3'd1);

    for (genvar i = 0; i < width; i++) begin : g_btn
        logic [1:0] steady_cnt;  // High samples in a row, saturates
        logic       fired;       // Press already reported
        logic       pulse_q;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                steady_cnt <= '0;
                fired      <= 1'b0;
                pulse_q    <= 1'b0;
            end else begin
                pulse_q <= 1'b0;                  // Pulse lasts one clock
                if (tick) begin
                    if (in_sync[i]) begin
                        if (steady_cnt != pulse_cnt_max - 2'd1)
                            steady_cnt <= steady_cnt + 2'd1;
                        // Last needed sample, report once
                        if (steady_cnt == pulse_cnt_max - 2'd1 && !fired) begin
                            pulse_q <= 1'b1;
                            fired   <= 1'b1;
                        end
                    end else begin
                        steady_cnt <= '0;         // Released, arm again
                        fired      <= 1'b0;
                    end
                end
            end
        end

        assign out[i] = pulse_q;
    end

endmodule

`default_nettype wire

// ==== source/uart.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart import board_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic serial_rx,
    output logic serial_tx,
    byte_if.uart_side bus
);

    logic       rx_pin_q;    // Pin register
    logic       rx_s;        // Synchronized RX line
    logic       rx_active;   // Inside a frame
    logic [3:0] rx_clk_cnt;
    logic [3:0] rx_bit_cnt;  // 0 start, 1 to 8 data, 9 stop
    logic [7:0] rx_shift;
    logic       rx_valid_q;
    logic       rx_sample;   // Middle of the current bit

    logic       tx_busy_q;
    logic [3:0] tx_clk_cnt;
    logic [3:0] tx_bit_cnt;
    logic [9:0] tx_shift;    // Stop, data, start
    logic       tx_line;
    logic       tx_bit_end;

    // Pin registers, idle high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_pin_q  <= 1'b1;
            rx_s      <= 1'b1;
            serial_tx <= 1'b1;
        end else begin
            rx_pin_q  <= serial_rx;
            rx_s      <= rx_pin_q;
            serial_tx <= tx_line;
        end
    end

    // Half a bit for the start bit, a full bit after that
    assign rx_sample = rx_active &&
                       (rx_bit_cnt == 4'd0 ? rx_clk_cnt == (clks_per_bit >> 1) - 4'd1
                                           : rx_clk_cnt == clks_per_bit - 4'd1);

    // Receiver control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_active  <= 1'b0;
            rx_clk_cnt <= '0;
            rx_bit_cnt <= '0;
            rx_valid_q <= 1'b0;
        end else begin
            rx_valid_q <= 1'b0;
            if (!rx_active) begin
                if (!rx_s) begin                   // Falling edge, maybe a start bit
                    rx_active  <= 1'b1;
                    rx_clk_cnt <= '0;
                    rx_bit_cnt <= '0;
                end
            end else if (rx_sample) begin
                rx_clk_cnt <= '0;
                if (rx_bit_cnt == 4'd0) begin
                    if (rx_s)
                        rx_active <= 1'b0;         // Glitch, not a start bit
                    else
                        rx_bit_cnt <= 4'd1;
                end else if (rx_bit_cnt == 4'd9) begin
                    rx_active  <= 1'b0;
                    rx_valid_q <= rx_s;            // Bad stop bit drops the frame
                end else begin
                    rx_bit_cnt <= rx_bit_cnt + 4'd1;
                end
            end else begin
                rx_clk_cnt <= rx_clk_cnt + 4'd1;
            end
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (rx_sample && rx_bit_cnt != 4'd0 && rx_bit_cnt != 4'd9)
            rx_shift <= {rx_s, rx_shift[7:1]};
    end

    assign bus.rx_data  = rx_shift;
    assign bus.rx_valid = rx_valid_q;

    assign tx_bit_end = (tx_clk_cnt == clks_per_bit - 4'd1);

    // Transmitter control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_busy_q  <= 1'b0;
            tx_clk_cnt <= '0;
            tx_bit_cnt <= '0;
        end else if (!tx_busy_q) begin
            if (bus.tx_start) begin
                tx_busy_q  <= 1'b1;
                tx_clk_cnt <= '0;
                tx_bit_cnt <= '0;
            end
        end else if (tx_bit_end) begin
            tx_clk_cnt <= '0;
            if (tx_bit_cnt == 4'd9)
                tx_busy_q <= 1'b0;                 // Stop bit done
            else
                tx_bit_cnt <= tx_bit_cnt + 4'd1;
        end else begin
            tx_clk_cnt <= tx_clk_cnt + 4'd1;
        end
    end

    // Frame shift register
    always_ff @(posedge clk) begin
        if (!tx_busy_q && bus.tx_start)
            tx_shift <= {1'b1, bus.tx_data, 1'b0};
        else if (tx_busy_q && tx_bit_end)
            tx_shift <= {1'b1, tx_shift[9:1]};
    end

    assign tx_line     = tx_busy_q ? tx_shift[0] : 1'b1;
    assign bus.tx_busy = tx_busy_q;

endmodule

`default_nettype wire

// ==== source/csr_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module csr_unit import board_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [3:0]  pressed,   // Press pulses from the button parser
    input  logic [1:0]  switches,
    byte_if.host_side   bus,
    output logic [31:0] csr,
    output logic [5:0]  leds
);

    cmd_t       cmd;
    logic       write_hit;
    logic       read_hit;
    logic       clear;
    logic       pend_valid;  // Reply waiting for the transmitter
    logic [7:0] pend_data;
    logic       tx_start_q;

    assign cmd = bus.rx_data;

    assign write_hit = bus.rx_valid && (cmd.wr.op == op_write);
    assign read_hit  = bus.rx_valid && (cmd.rd.op == op_read);
    assign clear     = pressed[0] & switches[1];  // Button 0 with switch 1 wipes the csr

    // csr word, LED value in byte 0 and press counts above it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            csr <= '0;
        end else if (clear) begin
            csr <= '0;
        end else begin
            if (write_hit)
                csr[7:0] <= {2'b00, cmd.wr.led_val};
            for (int i = 1; i < 4; i++) begin
                if (pressed[i])
                    csr[8*i +: 8] <= csr[8*i +: 8] + 8'd1;  // Wraps at 255
            end
        end
    end

    // One entry reply slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_valid <= 1'b0;
            tx_start_q <= 1'b0;
        end else begin
            tx_start_q <= 1'b0;
            if (read_hit) begin
                pend_valid <= 1'b1;                // Newer read replaces an old one
            end else if (pend_valid && !bus.tx_busy) begin
                tx_start_q <= 1'b1;
                pend_valid <= 1'b0;
            end
        end
    end

    // Selected csr byte
    always_ff @(posedge clk) begin
        if (read_hit)
            pend_data <= csr[{cmd.rd.sel, 3'b000} +: 8];
    end

    assign bus.tx_data  = pend_data;
    assign bus.tx_start = tx_start_q;

    // Switch 0 shows the button 1 count instead of the written value
    assign leds = switches[0] ? csr[13:8] : csr[5:0];

endmodule

`default_nettype wire

// ==== source/board_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module board_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [3:0]  buttons,
    input  logic [1:0]  switches,
    input  logic        serial_rx,
    output logic        serial_tx,
    output logic [5:0]  leds,
    output logic [31:0] csr        // Routed out for observation
);

    logic [3:0] buttons_pressed;   // One clock per debounced press

    byte_if bus ();                // UART to command unit

    button_parser #(
        .width(4)
    ) bp (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (buttons),
        .out   (buttons_pressed)
    );

    uart uart (
        .clk       (clk),
        .rst_n     (rst_n),
        .serial_rx (serial_rx),
        .serial_tx (serial_tx),
        .bus       (bus)
    );

    csr_unit csr_ctl (
        .clk      (clk),
        .rst_n    (rst_n),
        .pressed  (buttons_pressed),
        .switches (switches),
        .bus      (bus),
        .csr      (csr),
        .leds     (leds)
    );

endmodule

`default_nettype wire

// ==== sim/tb_board_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_board_top import board_pkg::*; ();

    localparam int press_hold = 2 * sample_cnt_max * (pulse_cnt_max + 1);  // Sure press
    localparam int glitch_max = sample_cnt_max * (pulse_cnt_max - 1);      // Glitch stays below
    localparam int settle     = 4 * sample_cnt_max;  // Low time so the parser rearms
    localparam int wait_limit = 200;                 // Clocks allowed for any response

    logic        clk;
    logic        rst_n;
    logic [3:0]  buttons;
    logic [1:0]  switches;
    logic        serial_rx;
    logic        serial_tx;
    logic [5:0]  leds;
    logic [31:0] csr;

    integer      seed;
    logic [31:0] rnd;
    logic [7:0]  model_csr [4];  // Expected csr bytes 0 to 3
    logic [1:0]  model_sw;       // Switch state as the model sees it

    board_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .buttons   (buttons),
        .switches  (switches),
        .serial_rx (serial_rx),
        .serial_tx (serial_tx),
        .leds      (leds),
        .csr       (csr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    function automatic logic [31:0] model_word();
        return {model_csr[3], model_csr[2], model_csr[1], model_csr[0]};
    endfunction

    // Switch 0 picks the button 1 count
    function automatic logic [5:0] model_leds();
        return model_sw[0] ? model_csr[1][5:0] : model_csr[0][5:0];
    endfunction

    task automatic fail_run(input string what);
        $display("ERROR at %0t: %s", $time, what);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s, got %h expected %h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "run stopped");
        end
    endtask

    task automatic check_leds(input logic [5:0] got, input logic [5:0] exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s, got %h expected %h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "run stopped");
        end
    endtask

    task automatic check_csr(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s, got %h expected %h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "run stopped");
        end
    endtask

    // 8N1 frame into serial_rx, LSB first
    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        repeat (clks_per_bit) @(posedge clk);        // Idle gap so frames never touch
        repeat (10) begin
            @(posedge clk);
            serial_rx <= frame[0];
            frame = {1'b1, frame[9:1]};
            repeat (clks_per_bit - 1) @(posedge clk);
        end
    endtask

    // Looks for a start bit on serial_tx, samples on falling edges
    task automatic recv_byte(output logic [7:0] data, output logic seen);
        int i;
        seen = 1'b0;
        data = '0;
        for (i = 0; i < wait_limit && !seen; i++) begin
            @(negedge clk);
            seen = !serial_tx;
        end
        if (seen) begin
            repeat (clks_per_bit >> 1) @(negedge clk);  // Middle of the start bit
            repeat (8) begin
                repeat (clks_per_bit) @(negedge clk);
                data = {serial_tx, data[7:1]};
            end
            repeat (clks_per_bit) @(negedge clk);
            if (!serial_tx)
                fail_run("reply frame has a low stop bit");
        end
    endtask

    task automatic write_check(input logic [5:0] val);
        cmd_t cmd;
        int   i;
        cmd.wr.op      = op_write;
        cmd.wr.led_val = val;
        send_byte(cmd);
        model_csr[0] = {2'b00, val};
        i = 0;
        do begin
            @(negedge clk);
            i++;
        end while (leds !== model_leds() && i < wait_limit);
        if (leds !== model_leds())
            fail_run("timed out waiting for the LEDs to take the written value");
        else
            check_csr(csr, model_word(), "csr after write");
    endtask

    task automatic read_check(input logic [1:0] sel);
        cmd_t       cmd;
        logic [7:0] data;
        logic       seen;
        rnd = $random(seed);
        cmd.rd.op   = op_read;
        cmd.rd.rsvd = rnd[3:0];  // Unused bits get noise
        cmd.rd.sel  = sel;
        send_byte(cmd);
        recv_byte(data, seen);
        if (!seen)
            fail_run("timed out waiting for the read reply");
        else
            check_byte(data, model_csr[sel], "read reply");
    endtask

    task automatic press(input logic [1:0] btn, input int hold);
        @(posedge clk);
        buttons[btn] <= 1'b1;
        repeat (hold) @(posedge clk);
        buttons[btn] <= 1'b0;
        repeat (settle) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic set_switches(input logic [1:0] val);
        @(posedge clk);
        switches <= val;
        model_sw = val;
        @(negedge clk);
    endtask

    initial begin
        int         n;
        int         glitch;
        logic [1:0] btn;
        logic [7:0] junk;
        logic [7:0] reply;
        logic       seen;
        seed      = 32'h87222c21;
        rst_n     <= 1'b0;
        buttons   <= '0;
        switches  <= '0;
        serial_rx <= 1'b1;
        model_sw  = '0;
        model_csr = '{default: '0};
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_csr(csr, 32'h0, "csr after reset");
        check_leds(leds, 6'h0, "LEDs after reset");
        if (serial_tx !== 1'b1)
            fail_run("serial TX line is not idle after reset");

        for (n = 0; n < 16; n++) begin       // Random writes, then random reads
            rnd = $random(seed);
            write_check(rnd[5:0]);
            read_check(rnd[9:8]);
        end

        // Enough presses per button to wrap each count
        for (n = 0; n < 1400; n++) begin
            rnd = $random(seed);
            btn = 2'd1 + 2'(rnd % 32'd3);
            if (rnd[4:3] == 2'd0) begin
                glitch = 1 + rnd[15:8] % (glitch_max - 1);
                press(btn, glitch);          // Too short, no count
            end else begin
                press(btn, press_hold);
                model_csr[btn] = model_csr[btn] + 8'd1;
            end
            check_csr(csr, model_word(), "csr after press");
            if (n % 32 == 31)
                read_check(rnd[21:20]);
            if (n % 64 == 63) begin
                set_switches(2'b01);
                check_leds(leds, model_leds(), "LEDs with switch 0 high");
                set_switches(2'b00);
                check_leds(leds, model_leds(), "LEDs back on written value");
            end
        end

        rnd = $random(seed);
        write_check(rnd[5:0] | 6'h01);       // Nonzero byte 0 before the clear
        press(2'd0, press_hold);             // Switch 1 low, nothing happens
        check_csr(csr, model_word(), "csr after button 0 alone");
        set_switches(2'b10);
        press(2'd0, press_hold);
        model_csr = '{default: '0};
        check_csr(csr, model_word(), "csr after clear");
        check_leds(leds, model_leds(), "LEDs after clear");
        set_switches(2'b00);
        for (n = 0; n < 4; n++)
            read_check(2'(n));               // All counts read back as zero

        rnd = $random(seed);
        write_check(rnd[5:0] | 6'h01);
        for (n = 0; n < 6; n++) begin
            rnd = $random(seed);
            junk = rnd[7:0];
            junk[7:6] = {2{rnd[8]}};         // Opcode 00 or 11
            send_byte(junk);
            recv_byte(reply, seen);
            if (seen)
                fail_run("a byte with opcode 00 or 11 produced a reply");
            else
                check_csr(csr, model_word(), "csr after ignored byte");
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
source/board_pkg.sv
source/byte_if.sv
source/button_parser.sv
source/uart.sv
source/csr_unit.sv
source/board_top.sv
sim/tb_board_top.sv

// ==== Makefile ====
# Verilator build and run of the board testbench

TOP = tb_board_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -f files.f -o sim_board

run: compile
	./obj_dir/sim_board > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
